// File: hdl/hci_params.svh
// size macros of the banked scratchpad
// bank count, lanes per wide request and bank depth
`ifndef HCI_PARAMS_SVH
`define HCI_PARAMS_SVH

// number of word-interleaved banks, a power of two
`define HCI_NB_BANKS 8

// 32-bit words per wide request, not more than the bank count
`define HCI_NB_IN_WORDS 4

// words held by each bank
`define HCI_BANK_ROWS 256

// width of one data word and of its byte enables
`define HCI_WORD_BITS 32
`define HCI_BE_BITS 4

`endif

// File: hdl/hci_pkg.sv
// shared vector types of the banked scratchpad
// word, byte enable, wide port, address and bank index types
`include "hci_params.svh"

package hci_pkg;

  // one bank word and its byte enables
  typedef logic [`HCI_WORD_BITS-1:0] word_t;
  typedef logic [`HCI_BE_BITS-1:0] be_t;

  // wide accelerator port, all lanes packed with lane 0 at the bottom
  typedef logic [`HCI_NB_IN_WORDS*`HCI_WORD_BITS-1:0] wide_data_t;
  typedef logic [`HCI_NB_IN_WORDS*`HCI_BE_BITS-1:0] wide_be_t;

  // byte address as seen on the wide port
  typedef logic [31:0] byte_addr_t;

  // bank index, also used for the rotation offset
  typedef logic [$clog2(`HCI_NB_BANKS)-1:0] bank_sel_t;

  // word address inside one bank
  typedef logic [$clog2(`HCI_BANK_ROWS)-1:0] row_addr_t;

  // one bit per bank
  typedef logic [`HCI_NB_BANKS-1:0] bank_mask_t;

endpackage

// File: hdl/hci_router.sv
// request router of the banked scratchpad
// address decode, lane rotation onto banks, row carry, all-banks grant
`timescale 1ns/100ps
`include "hci_params.svh"

module hci_router import hci_pkg::*; (
  // wide request
  input  logic       req_i,
  input  logic       we_i,
  input  byte_addr_t addr_i,
  input  wide_be_t   be_i,
  input  wide_data_t wdata_i,
  // per-bank grant levels
  input  bank_mask_t bank_gnt_i,
  output logic       gnt_o,
  // per-bank requests
  output bank_mask_t bank_req_o,
  output logic       bank_we_o,
  output row_addr_t  bank_row_o   [`HCI_NB_BANKS],
  output be_t        bank_be_o    [`HCI_NB_BANKS],
  output word_t      bank_wdata_o [`HCI_NB_BANKS],
  // accepted request towards the gather stage
  output logic       acc_o,
  output bank_sel_t  acc_offset_o
);

  localparam int unsigned SEL_W = $bits(bank_sel_t);
  localparam int unsigned ROW_W = $bits(row_addr_t);

  bank_sel_t  offset;
  row_addr_t  row;
  bank_mask_t touched;
  logic       all_free;

  // bits 1:0 select a byte inside the word and are dropped
  // the next bits pick the starting bank, the ones above pick the row
  assign offset = addr_i[2 +: SEL_W];
  assign row    = addr_i[2+SEL_W +: ROW_W];

  // walk the banks and find which lane, if any, lands on each one
  always_comb begin : route_comb
    bank_sel_t   lane;
    int unsigned lane_idx;
    touched = '0;
    for (int b = 0; b < `HCI_NB_BANKS; b++) begin
      // lane k sits on bank offset+k, so bank b gets lane b-offset
      // the subtraction wraps within the bank index width
      lane       = bank_sel_t'(b) - offset;
      touched[b] = (lane < `HCI_NB_IN_WORDS);
      lane_idx   = touched[b] ? int'(lane) : 0;

      // banks below the offset hold lanes that wrapped past the last bank
      // those lanes live one row higher, wrapping at the bank depth
      if (bank_sel_t'(b) < offset) begin
        bank_row_o[b] = row + row_addr_t'(1);
      end else begin
        bank_row_o[b] = row;
      end

      // untouched banks see a quiet bus
      if (touched[b]) begin
        bank_be_o[b]    = be_i[lane_idx*`HCI_BE_BITS +: `HCI_BE_BITS];
        bank_wdata_o[b] = wdata_i[lane_idx*`HCI_WORD_BITS +: `HCI_WORD_BITS];
      end else begin
        bank_be_o[b]    = '0;
        bank_wdata_o[b] = '0;
      end
    end
  end

  // every touched bank must be free, otherwise nothing moves
  // this keeps a wide write from landing only in part
  assign all_free = &(bank_gnt_i | ~touched);
  assign gnt_o    = req_i & all_free;

  // strobe only the touched banks, and only in a granted cycle
  assign bank_req_o = touched & {`HCI_NB_BANKS{gnt_o}};
  assign bank_we_o  = we_i;

  // acceptance info for the response path
  // gnt_o already includes req_i
  assign acc_o        = gnt_o;
  assign acc_offset_o = offset;

endmodule

// File: hdl/hci_bank.sv
// one single-port SRAM bank of the scratchpad
// 32-bit words, byte-enabled writes, busy-based grant, registered read data
`timescale 1ns/100ps
`include "hci_params.svh"

module hci_bank import hci_pkg::*; (
  input  logic      clk_i,
  // request from the router
  input  logic      req_i,
  input  logic      we_i,
  // competing initiator holds the bank
  input  logic      busy_i,
  input  row_addr_t row_i,
  input  be_t       be_i,
  input  word_t     wdata_i,
  // handshake and read data
  output logic      gnt_o,
  output word_t     rdata_o
);

  // bank storage
  word_t mem_q [`HCI_BANK_ROWS];
  word_t rdata_q;

  // the bank is ours whenever the other initiator leaves it alone
  assign gnt_o = ~busy_i;

  // read-before-write on every strobe
  // a write response therefore returns the previous contents
  always_ff @(posedge clk_i) begin
    if (req_i && gnt_o) begin
      rdata_q <= mem_q[row_i];
      if (we_i) begin
        // only enabled byte lanes are updated
        for (int i = 0; i < `HCI_BE_BITS; i++) begin
          if (be_i[i]) begin
            mem_q[row_i][i*8 +: 8] <= wdata_i[i*8 +: 8];
          end
        end
      end
    end
  end

  // read word is held until the next strobe
  assign rdata_o = rdata_q;

endmodule

// File: hdl/hci_gather.sv
// response gather of the banked scratchpad
// acceptance and offset registers, un-rotation of bank read data,
// response valid one cycle after the grant
`timescale 1ns/100ps
`include "hci_params.svh"

module hci_gather import hci_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_ni,
  input  logic       clear_i,
  // accepted request from the router
  input  logic       acc_i,
  input  bank_sel_t  acc_offset_i,
  // registered read words of all banks
  input  word_t      bank_rdata_i [`HCI_NB_BANKS],
  // wide response
  output logic       r_valid_o,
  output wide_data_t r_data_o
);

  logic      acc_q;
  bank_sel_t offset_q;

  // one register stage, matching the bank read latency
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      acc_q    <= 1'b0;
      offset_q <= '0;
    end else if (clear_i) begin
      // drop any response in flight
      acc_q    <= 1'b0;
      offset_q <= '0;
    end else begin
      acc_q <= acc_i;
      // offset only matters for the cycle after an acceptance
      if (acc_i) begin
        offset_q <= acc_offset_i;
      end
    end
  end

  // response is valid exactly the cycle after the grant
  // reads and writes alike
  assign r_valid_o = acc_q;

  // undo the rotation, lane k comes back from bank offset+k
  always_comb begin : unrotate_comb
    bank_sel_t src;
    r_data_o = '0;
    for (int k = 0; k < `HCI_NB_IN_WORDS; k++) begin
      // index wraps within the bank count
      src = offset_q + bank_sel_t'(k);
      r_data_o[k*`HCI_WORD_BITS +: `HCI_WORD_BITS] = bank_rdata_i[src];
    end
  end

endmodule

// File: hdl/hci_banked_mem.sv
// top level of the banked scratchpad
// router, generate loop of SRAM banks, response gather
`timescale 1ns/100ps
`include "hci_params.svh"

module hci_banked_mem import hci_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_ni,
  input  logic       clear_i,
  // wide request
  input  logic       req_i,
  input  logic       we_i,
  input  byte_addr_t addr_i,
  input  wide_be_t   be_i,
  input  wide_data_t wdata_i,
  // wide response
  output logic       gnt_o,
  output logic       r_valid_o,
  output wide_data_t r_data_o,
  // busy level from a competing initiator, one bit per bank
  input  bank_mask_t bank_busy_i
);

  // router to banks
  bank_mask_t bank_req;
  logic       bank_we;
  row_addr_t  bank_row   [`HCI_NB_BANKS];
  be_t        bank_be    [`HCI_NB_BANKS];
  word_t      bank_wdata [`HCI_NB_BANKS];

  // banks to router and gather
  bank_mask_t bank_gnt;
  word_t      bank_rdata [`HCI_NB_BANKS];

  // router to gather
  logic       acc;
  bank_sel_t  acc_offset;

  // lane rotation and grant, purely combinational
  hci_router i_router (
    .req_i        ( req_i      ),
    .we_i         ( we_i       ),
    .addr_i       ( addr_i     ),
    .be_i         ( be_i       ),
    .wdata_i      ( wdata_i    ),
    .bank_gnt_i   ( bank_gnt   ),
    .gnt_o        ( gnt_o      ),
    .bank_req_o   ( bank_req   ),
    .bank_we_o    ( bank_we    ),
    .bank_row_o   ( bank_row   ),
    .bank_be_o    ( bank_be    ),
    .bank_wdata_o ( bank_wdata ),
    .acc_o        ( acc        ),
    .acc_offset_o ( acc_offset )
  );

  // word-interleaved banks, all sharing the write enable
  for (genvar b = 0; b < `HCI_NB_BANKS; b++) begin : gen_bank
    hci_bank i_bank (
      .clk_i   ( clk_i          ),
      .req_i   ( bank_req[b]    ),
      .we_i    ( bank_we        ),
      .busy_i  ( bank_busy_i[b] ),
      .row_i   ( bank_row[b]    ),
      .be_i    ( bank_be[b]     ),
      .wdata_i ( bank_wdata[b]  ),
      .gnt_o   ( bank_gnt[b]    ),
      .rdata_o ( bank_rdata[b]  )
    );
  end

  // response path, one cycle behind the grant
  hci_gather i_gather (
    .clk_i        ( clk_i      ),
    .rst_ni       ( rst_ni     ),
    .clear_i      ( clear_i    ),
    .acc_i        ( acc        ),
    .acc_offset_i ( acc_offset ),
    .bank_rdata_i ( bank_rdata ),
    .r_valid_o    ( r_valid_o  ),
    .r_data_o     ( r_data_o   )
  );

endmodule

// File: dv/hci_tb_checks.svh
// typed compare tasks of the scratchpad testbench
// wide data, single word and single level checks, plus the common stop
`ifndef HCI_TB_CHECKS_SVH
`define HCI_TB_CHECKS_SVH

// first error ends the run
task automatic abort_run();
  $display("FAIL: see errors above");
  $fatal(1, "simulation stopped on the first error");
endtask

// whole wide response
task automatic check_data(input string name, input wide_data_t exp, input wide_data_t act);
  if (act !== exp) begin
    errors++;
    $display("ERR %s: expected %h actual %h", name, exp, act);
    abort_run();
  end
endtask

// one lane word, used for bank placement
task automatic check_word(input string name, input word_t exp, input word_t act);
  if (act !== exp) begin
    errors++;
    $display("ERR %s: expected %h actual %h", name, exp, act);
    abort_run();
  end
endtask

// handshake levels such as gnt and r_valid
task automatic check_bit(input string name, input logic exp, input logic act);
  if (act !== exp) begin
    errors++;
    $display("ERR %s: expected %b actual %b", name, exp, act);
    abort_run();
  end
endtask

`endif

// File: dv/hci_tb.sv
// testbench of the banked scratchpad
// clock, reset, DUT, shadow memory, timeout and directed tests
`timescale 1ns/100ps
`include "hci_params.svh"

module hci_tb import hci_pkg::*; ();

  localparam int unsigned MAX_CYCLES = 2000;
  localparam int unsigned BANKS      = `HCI_NB_BANKS;
  localparam int unsigned LANES      = `HCI_NB_IN_WORDS;
  localparam int unsigned ROWS       = `HCI_BANK_ROWS;

  logic       clk_i;
  logic       rst_ni;
  logic       clear;
  logic       req;
  logic       we;
  byte_addr_t addr;
  wide_be_t   be;
  wide_data_t wdata;
  logic       gnt;
  logic       r_valid;
  wide_data_t r_data;
  bank_mask_t bank_busy;

  // expected contents, indexed by bank and row
  word_t       shadow [BANKS][ROWS];
  int unsigned cycles;
  int unsigned errors;

  `include "hci_tb_checks.svh"

  hci_banked_mem dut_i (
    .clk_i       ( clk_i     ),
    .rst_ni      ( rst_ni    ),
    .clear_i     ( clear     ),
    .req_i       ( req       ),
    .we_i        ( we        ),
    .addr_i      ( addr      ),
    .be_i        ( be        ),
    .wdata_i     ( wdata     ),
    .gnt_o       ( gnt       ),
    .r_valid_o   ( r_valid   ),
    .r_data_o    ( r_data    ),
    .bank_busy_i ( bank_busy )
  );

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  // run limit, well above the preload plus all tests
  always @(posedge clk_i) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("timeout: the tests did not finish within %0d cycles", MAX_CYCLES);
      abort_run();
    end
  end

  // lane k lands on bank offset+k, one row up once it wraps past the last bank
  function automatic int unsigned lane_bank(byte_addr_t a, int unsigned k);
    return ((a >> 2) % BANKS + k) % BANKS;
  endfunction

  function automatic int unsigned lane_row(byte_addr_t a, int unsigned k);
    int unsigned row;
    row = (a >> 2) / BANKS % ROWS;
    return ((a >> 2) % BANKS + k >= BANKS) ? (row + 1) % ROWS : row;
  endfunction

  function automatic bank_mask_t touched_banks(byte_addr_t a);
    bank_mask_t m;
    m = '0;
    for (int k = 0; k < LANES; k++) m[lane_bank(a, k)] = 1'b1;
    return m;
  endfunction

  function automatic wide_data_t shadow_read(byte_addr_t a);
    wide_data_t d;
    for (int k = 0; k < LANES; k++) d[k*32 +: 32] = shadow[lane_bank(a, k)][lane_row(a, k)];
    return d;
  endfunction

  task automatic shadow_write(byte_addr_t a, wide_be_t m, wide_data_t d);
    for (int k = 0; k < LANES; k++) begin
      for (int i = 0; i < 4; i++) begin
        if (m[k*4+i]) shadow[lane_bank(a, k)][lane_row(a, k)][i*8 +: 8] = d[k*32+i*8 +: 8];
      end
    end
  endtask

  function automatic wide_data_t random_wide();
    wide_data_t d;
    for (int k = 0; k < LANES; k++) d[k*32 +: 32] = $urandom;
    return d;
  endfunction

  // pattern depends on bank and row together
  function automatic word_t fill_word(int unsigned b, int unsigned r);
    int unsigned w;
    w = r * BANKS + b;
    return word_t'(32'h5a00_0000 ^ (w << 16) ^ w);
  endfunction

  // one request with optional busy held for some cycles, then its response
  task automatic access(input string name, input logic wr, input byte_addr_t a,
                        input wide_be_t m, input wide_data_t d, input bank_mask_t busy_pat,
                        input int unsigned hold, output wide_data_t rsp);
    wide_data_t  exp_rsp;
    bank_mask_t  blocking;
    int unsigned waited;
    logic        granted;
    @(posedge clk_i);
    #1;
    req       = 1'b1;
    we        = wr;
    addr      = a;
    be        = m;
    wdata     = d;
    bank_busy = busy_pat;
    blocking  = busy_pat & touched_banks(a);
    waited    = 0;
    granted   = 1'b0;
    while (!granted) begin
      @(negedge clk_i);
      check_bit({name, " gnt"}, (blocking == '0), gnt);
      check_bit({name, " r_valid before grant"}, 1'b0, r_valid);
      if (blocking == '0) begin
        granted = 1'b1;
      end else begin
        @(posedge clk_i);
        #1;
        waited++;
        if (waited >= hold) begin
          bank_busy = '0;
          blocking  = '0;
        end
      end
    end
    // old contents come back, the write lands at this edge
    exp_rsp = shadow_read(a);
    if (wr) shadow_write(a, m, d);
    @(posedge clk_i);
    #1;
    req       = 1'b0;
    we        = 1'b0;
    bank_busy = '0;
    @(negedge clk_i);
    check_bit({name, " r_valid"}, 1'b1, r_valid);
    check_data(name, exp_rsp, r_data);
    rsp = r_data;
  endtask

  // back-to-back aligned writes over the whole memory
  task automatic preload();
    for (int r = 0; r < ROWS; r++) begin
      for (int h = 0; h < BANKS / LANES; h++) begin
        @(posedge clk_i);
        #1;
        req  = 1'b1;
        we   = 1'b1;
        be   = '1;
        addr = byte_addr_t'((r * BANKS + h * LANES) * 4);
        for (int k = 0; k < LANES; k++) begin
          wdata[k*32 +: 32]         = fill_word(h * LANES + k, r);
          shadow[h * LANES + k][r]  = fill_word(h * LANES + k, r);
        end
        @(negedge clk_i);
        check_bit("preload gnt", 1'b1, gnt);
      end
    end
    @(posedge clk_i);
    #1;
    req = 1'b0;
    we  = 1'b0;
  endtask

  task automatic test_aligned();
    wide_data_t d;
    wide_data_t rsp;
    d = random_wide();
    access("aligned write", 1'b1, 32'h0000_0040, '1, d, '0, 0, rsp);
    access("aligned read", 1'b0, 32'h0000_0040, '0, '0, '0, 0, rsp);
    check_data("aligned round trip", d, rsp);
  endtask

  task automatic test_rotation();
    wide_data_t  d;
    wide_data_t  rsp;
    byte_addr_t  a;
    int unsigned row;
    for (int off = 5; off <= 7; off++) begin
      // offset 7 sits on the last row so the carry wraps to row 0
      row = (off == 7) ? ROWS - 1 : 20 + off;
      a   = byte_addr_t'((row * BANKS + off) * 4);
      d   = random_wide();
      access($sformatf("rotation write off %0d", off), 1'b1, a, '1, d, '0, 0, rsp);
      access($sformatf("rotation read off %0d", off), 1'b0, a, '0, '0, '0, 0, rsp);
      check_data($sformatf("rotation round trip off %0d", off), d, rsp);
      access("rotation upper half", 1'b0, byte_addr_t'((row * BANKS + LANES) * 4), '0, '0,
             '0, 0, rsp);
      check_word("rotation lane 0 placement", d[31:0], rsp[(off - LANES) * 32 +: 32]);
      access("rotation next row", 1'b0, byte_addr_t'((row + 1) % ROWS * BANKS * 4), '0, '0,
             '0, 0, rsp);
      check_word("rotation wrapped lane placement", d[(BANKS - off) * 32 +: 32], rsp[31:0]);
    end
  endtask

  task automatic test_byte_enables();
    wide_data_t d0;
    wide_data_t d1;
    wide_data_t exp;
    wide_data_t rsp;
    wide_be_t   m;
    m  = wide_be_t'(16'h8631);
    d0 = random_wide();
    d1 = random_wide();
    for (int i = 0; i < LANES * 4; i++) exp[i*8 +: 8] = m[i] ? d1[i*8 +: 8] : d0[i*8 +: 8];
    access("be full write", 1'b1, 32'h0000_012c, '1, d0, '0, 0, rsp);
    access("be sparse write", 1'b1, 32'h0000_012c, m, d1, '0, 0, rsp);
    check_data("be write old data", d0, rsp);
    access("be read", 1'b0, 32'h0000_012c, '0, '0, '0, 0, rsp);
    check_data("be merged data", exp, rsp);
  endtask

  task automatic test_backpressure();
    wide_data_t d;
    wide_data_t rsp;
    d = random_wide();
    // offset 2 touches banks 2 to 5, bank 4 busy, request then withdrawn
    @(posedge clk_i);
    #1;
    req       = 1'b1;
    we        = 1'b1;
    addr      = 32'h0000_0208;
    be        = '1;
    wdata     = d;
    bank_busy = 8'b0001_0000;
    repeat (3) begin
      @(negedge clk_i);
      check_bit("busy hold gnt", 1'b0, gnt);
      @(posedge clk_i);
      #1;
    end
    req       = 1'b0;
    bank_busy = '0;
    // shadow is untouched, so this read proves nothing was written
    access("busy unchanged read", 1'b0, 32'h0000_0208, '0, '0, '0, 0, rsp);
    access("busy write", 1'b1, 32'h0000_0208, '1, d, 8'b0000_1000, 3, rsp);
    access("busy read", 1'b0, 32'h0000_0208, '0, '0, '0, 0, rsp);
    check_data("busy round trip", d, rsp);
    access("untouched busy write", 1'b1, 32'h0000_0208, '1, ~d, 8'b1100_0011, 4, rsp);
  endtask

  task automatic test_pipeline_clear();
    wide_data_t exp_q [$];
    byte_addr_t a;
    for (int i = 0; i <= 6; i++) begin
      @(posedge clk_i);
      #1;
      req = (i < 6);
      we  = 1'b0;
      if (i < 6) begin
        a    = byte_addr_t'(32'h0000_0400 + i * 12);
        addr = a;
        exp_q.push_back(shadow_read(a));
      end
      @(negedge clk_i);
      // gnt follows req, so it drops on the idle last step
      check_bit("pipeline gnt", logic'(i < 6), gnt);
      if (i > 0) begin
        check_bit("pipeline r_valid", 1'b1, r_valid);
        check_data("pipeline read", exp_q.pop_front(), r_data);
      end
    end
    // clear in the grant cycle kills the response
    @(posedge clk_i);
    #1;
    req   = 1'b1;
    addr  = 32'h0000_0404;
    clear = 1'b1;
    @(negedge clk_i);
    check_bit("clear gnt", 1'b1, gnt);
    @(posedge clk_i);
    #1;
    req   = 1'b0;
    clear = 1'b0;
    @(negedge clk_i);
    check_bit("clear r_valid", 1'b0, r_valid);
  endtask

  task automatic test_random();
    wide_data_t rsp;
    bank_mask_t busy_pat;
    for (int n = 0; n < 200; n++) begin
      busy_pat = ($urandom_range(0, 3) == 0) ? bank_mask_t'($urandom) : '0;
      access($sformatf("random %0d", n), logic'($urandom_range(0, 1)), byte_addr_t'($urandom),
             wide_be_t'($urandom), random_wide(), busy_pat, $urandom_range(1, 3), rsp);
    end
  endtask

  initial begin
    void'($urandom(37));
    cycles    = 0;
    errors    = 0;
    rst_ni    = 1'b0;
    clear     = 1'b0;
    req       = 1'b0;
    we        = 1'b0;
    addr      = '0;
    be        = '0;
    wdata     = '0;
    bank_busy = '0;
    repeat (2) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;
    @(negedge clk_i);
    check_bit("r_valid after reset", 1'b0, r_valid);
    preload();
    test_aligned();
    test_rotation();
    test_byte_enables();
    test_backpressure();
    test_pipeline_clear();
    test_random();
    @(posedge clk_i);
    if (errors == 0) begin
      $display("PASS: all tests");
      $finish;
    end else begin
      abort_run();
    end
  end

endmodule

// File: project.f
+incdir+hdl
+incdir+dv
hdl/hci_pkg.sv
hdl/hci_router.sv
hdl/hci_bank.sv
hdl/hci_gather.sv
hdl/hci_banked_mem.sv
dv/hci_tb.sv
